// File: design/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// sizing for the 16-bit teaching core

// data path and instruction width in bits
`define CPU_WORD_W 16

// word address bits of instruction and data memories
// each memory holds 2**CPU_MEM_AW words
`define CPU_MEM_AW 8

// general purpose registers
// r0 reads as zero regardless of writes
`define CPU_NUM_REGS 16

`endif

// File: design/cpu_pkg.sv
`include "cpu_macros.svh"

package cpu_pkg;

	// basic data word and register index
	typedef logic [`CPU_WORD_W-1:0] word_t;
	typedef logic [$clog2(`CPU_NUM_REGS)-1:0] reg_addr_t;

	// opcodes 5, 6, 7 and d are left out and retire as no-ops
	typedef enum logic [3:0] {
		OP_ADD = 4'h0, OP_SUB = 4'h1, OP_XOR = 4'h2, OP_SLL = 4'h3, OP_SRA = 4'h4,
		OP_LW = 4'h8, OP_SW = 4'h9, OP_LLB = 4'ha, OP_LHB = 4'hb, OP_B = 4'hc,
		OP_PCS = 4'he, OP_HLT = 4'hf
	} opcode_e;

	// alu operations, pass hands rd through for the byte merges
	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_XOR, ALU_SLL, ALU_SRA, ALU_PASS
	} alu_op_e;

	// source of the register write value
	typedef enum logic [2:0] {
		WB_ALU, WB_MEM, WB_PCS, WB_LLB, WB_LHB
	} wb_sel_e;

	// field view of any instruction word
	// rt doubles as imm4, rs and rt together form imm8
	typedef struct packed {
		opcode_e opcode;
		reg_addr_t rd;
		reg_addr_t rs;
		reg_addr_t rt;
	} instr_t;

	// decoded controls for one instruction
	typedef struct packed {
		alu_op_e alu_op;
		logic use_imm;
		logic reg_we;
		logic mem_we;
		wb_sel_e wb_sel;
		logic set_zf;
		logic set_nv;
		logic is_branch;
		logic is_halt;
	} ctrl_t;

	typedef struct packed {
		logic z;
		logic v;
		logic n;
	} flags_t;

	// instruction memory load port, word addressed
	typedef struct packed {
		logic en;
		logic [`CPU_MEM_AW-1:0] addr;
		word_t data;
	} imem_load_t;

	// everything one instruction did in its cycle
	typedef struct packed {
		logic valid;
		word_t pc;
		instr_t instr;
		logic reg_we;
		reg_addr_t rd;
		word_t reg_wdata;
		logic mem_we;
		word_t mem_addr;
		word_t mem_wdata;
		word_t next_pc;
	} retire_t;

endpackage

// File: design/fetch_unit.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module fetch_unit import cpu_pkg::*; (
	input logic clk,
	input logic reset,
	input logic run,
	input imem_load_t imem_load,
	input logic branch_taken,
	input word_t branch_target,
	output word_t pc,
	output word_t next_pc,
	output instr_t instr,
	output logic active,
	output logic hlt
);

	localparam int AW = `CPU_MEM_AW;

	// instruction storage, filled only through the load port
	word_t imem [0:(1 << AW)-1];

	word_t pc_q;
	logic hlt_q;
	logic is_hlt;
	word_t pc_plus2;

	// load port writes regardless of run or halt
	always_ff @(posedge clk) begin
		if (imem_load.en) begin
			imem[imem_load.addr] <= imem_load.data;
		end
	end

	// asynchronous read, pc is a byte address so drop bit 0
	assign instr = instr_t'(imem[pc_q[AW:1]]);

	assign active = run & ~hlt_q;
	assign is_hlt = (instr.opcode == OP_HLT);
	assign pc_plus2 = pc_q + word_t'(2);

	// hlt keeps the pc on itself
	// a taken branch wins over the sequential step
	always_comb begin
		if (is_hlt) begin
			next_pc = pc_q;
		end else if (branch_taken) begin
			next_pc = branch_target;
		end else begin
			next_pc = pc_plus2;
		end
	end

	// pc and halt only move in active cycles
	always_ff @(posedge clk) begin
		if (reset) begin
			pc_q <= '0;
			hlt_q <= 1'b0;
		end else if (active) begin
			pc_q <= next_pc;
			// hlt retires now and blocks everything from the next edge on
			if (is_hlt) begin
				hlt_q <= 1'b1;
			end
		end
	end

	assign pc = pc_q;
	assign hlt = hlt_q;

endmodule

// File: design/decode_unit.sv
`timescale 1ns/1ps

module decode_unit import cpu_pkg::*; (
	input instr_t instr,
	output ctrl_t ctrl,
	output reg_addr_t rd_addr1,
	output reg_addr_t rd_addr2
);

	// opcode to control fields
	always_comb begin
		// default is a no-op with every write off
		ctrl = '0;
		ctrl.alu_op = ALU_ADD;
		ctrl.wb_sel = WB_ALU;
		case (instr.opcode)
			OP_ADD, OP_SUB: begin
				ctrl.alu_op = (instr.opcode == OP_ADD) ? ALU_ADD : ALU_SUB;
				ctrl.reg_we = 1'b1;
				ctrl.set_zf = 1'b1;
				ctrl.set_nv = 1'b1;
			end
			OP_XOR: begin
				ctrl.alu_op = ALU_XOR;
				ctrl.reg_we = 1'b1;
				ctrl.set_zf = 1'b1;
			end
			OP_SLL, OP_SRA: begin
				// shift amount is imm4, not a register
				ctrl.alu_op = (instr.opcode == OP_SLL) ? ALU_SLL : ALU_SRA;
				ctrl.use_imm = 1'b1;
				ctrl.reg_we = 1'b1;
				ctrl.set_zf = 1'b1;
			end
			OP_LW: begin
				ctrl.reg_we = 1'b1;
				ctrl.wb_sel = WB_MEM;
			end
			OP_SW: ctrl.mem_we = 1'b1;
			OP_LLB, OP_LHB: begin
				// rd flows through the alu for the byte merge
				ctrl.alu_op = ALU_PASS;
				ctrl.reg_we = 1'b1;
				ctrl.wb_sel = (instr.opcode == OP_LLB) ? WB_LLB : WB_LHB;
			end
			OP_B: ctrl.is_branch = 1'b1;
			OP_PCS: begin
				ctrl.reg_we = 1'b1;
				ctrl.wb_sel = WB_PCS;
			end
			OP_HLT: ctrl.is_halt = 1'b1;
			default: ;
		endcase
	end

	// byte merges read their own destination
	assign rd_addr1 = (instr.opcode == OP_LLB || instr.opcode == OP_LHB) ? instr.rd : instr.rs;
	// store data comes from rd
	assign rd_addr2 = (instr.opcode == OP_SW) ? instr.rd : instr.rt;

endmodule

// File: design/register_file.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module register_file import cpu_pkg::*; (
	input logic clk,
	input logic reset,
	input reg_addr_t rd_addr1,
	input reg_addr_t rd_addr2,
	output word_t rd_data1,
	output word_t rd_data2,
	input logic we,
	input reg_addr_t wr_addr,
	input word_t wr_data
);

	word_t regs [0:`CPU_NUM_REGS-1];

	// one write per edge and none to r0
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `CPU_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// combinational reads
	// r0 keeps its reset value of zero
	assign rd_data1 = regs[rd_addr1];
	assign rd_data2 = regs[rd_addr2];

endmodule

// File: design/execute_unit.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module execute_unit import cpu_pkg::*; (
	input logic clk,
	input logic reset,
	input logic active,
	input instr_t instr,
	input ctrl_t ctrl,
	input word_t pc,
	input word_t rd_data1,
	input word_t rd_data2,
	output word_t alu_result,
	output word_t mem_addr,
	output logic branch_taken,
	output word_t branch_target
);

	localparam int W = `CPU_WORD_W;

	word_t op_b;
	flags_t flags_q;
	flags_t flags_new;
	logic [2:0] cond;
	logic [8:0] offset;
	logic cond_met;

	// imm4 is unsigned when used as a shift amount
	assign op_b = ctrl.use_imm ? word_t'(instr.rt) : rd_data2;

	always_comb begin
		case (ctrl.alu_op)
			ALU_ADD: alu_result = rd_data1 + op_b;
			ALU_SUB: alu_result = rd_data1 - op_b;
			ALU_XOR: alu_result = rd_data1 ^ op_b;
			ALU_SLL: alu_result = rd_data1 << op_b[3:0];
			ALU_SRA: alu_result = word_t'($signed(rd_data1) >>> op_b[3:0]);
			default: alu_result = rd_data1;
		endcase
	end

	// flags of the result, only latched when ctrl says so
	assign flags_new.z = (alu_result == '0);
	assign flags_new.n = alu_result[W-1];
	// signed overflow of the wrapped sum or difference
	// sub flips the sign test on the second operand
	assign flags_new.v = (ctrl.alu_op == ALU_SUB) ?
		((rd_data1[W-1] != op_b[W-1]) && (alu_result[W-1] != rd_data1[W-1])) :
		((rd_data1[W-1] == op_b[W-1]) && (alu_result[W-1] != rd_data1[W-1]));

	always_ff @(posedge clk) begin
		if (reset) begin
			flags_q <= '0;
		end else if (active) begin
			if (ctrl.set_zf) begin
				flags_q.z <= flags_new.z;
			end
			if (ctrl.set_nv) begin
				flags_q.v <= flags_new.v;
				flags_q.n <= flags_new.n;
			end
		end
	end

	// load and store address is rs plus sign extended imm4 in words
	assign mem_addr = rd_data1 + {{(W-5){instr.rt[3]}}, instr.rt, 1'b0};

	// branch fields overlay rd, rs and rt
	assign cond = instr.rd[3:1];
	assign offset = {instr.rd[0], instr.rs, instr.rt};
	assign branch_target = pc + word_t'(2) + {{(W-10){offset[8]}}, offset, 1'b0};

	// conditions look at the flags left by earlier instructions
	always_comb begin
		case (cond)
			3'b000: cond_met = ~flags_q.z;
			3'b001: cond_met = flags_q.z;
			3'b010: cond_met = ~flags_q.z & ~flags_q.n;
			3'b011: cond_met = flags_q.n;
			3'b100: cond_met = ~flags_q.n;
			3'b101: cond_met = flags_q.z | flags_q.n;
			3'b110: cond_met = flags_q.v;
			default: cond_met = 1'b1;
		endcase
	end

	assign branch_taken = ctrl.is_branch & cond_met;

endmodule

// File: design/writeback_unit.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module writeback_unit import cpu_pkg::*; (
	input logic clk,
	input logic reset,
	input logic active,
	input word_t pc,
	input instr_t instr,
	input ctrl_t ctrl,
	input word_t alu_result,
	input word_t mem_addr,
	input word_t store_data,
	input word_t next_pc,
	output logic reg_we,
	output word_t reg_wdata,
	output retire_t retire
);

	localparam int AW = `CPU_MEM_AW;

	word_t dmem [0:(1 << AW)-1];
	word_t load_data;
	logic mem_we;
	logic [7:0] imm8;

	// writes only happen for an instruction that retires
	assign mem_we = active & ctrl.mem_we;
	assign reg_we = active & ctrl.reg_we;

	// data memory clears on reset, byte address drops bit 0
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < (1 << AW); i++) begin
				dmem[i] <= '0;
			end
		end else if (mem_we) begin
			dmem[mem_addr[AW:1]] <= store_data;
		end
	end

	assign load_data = dmem[mem_addr[AW:1]];
	assign imm8 = {instr.rs, instr.rt};

	// alu result carries rd unchanged for the byte merges
	always_comb begin
		case (ctrl.wb_sel)
			WB_MEM: reg_wdata = load_data;
			WB_PCS: reg_wdata = pc + word_t'(2);
			WB_LLB: reg_wdata = {alu_result[15:8], imm8};
			WB_LHB: reg_wdata = {imm8, alu_result[7:0]};
			default: reg_wdata = alu_result;
		endcase
	end

	// retire record for this cycle
	always_comb begin
		retire.valid = active;
		retire.pc = pc;
		retire.instr = instr;
		retire.reg_we = reg_we;
		retire.rd = instr.rd;
		retire.reg_wdata = reg_wdata;
		retire.mem_we = mem_we;
		retire.mem_addr = mem_addr;
		retire.mem_wdata = store_data;
		retire.next_pc = next_pc;
	end

endmodule

// File: design/cpu.sv
`timescale 1ns/1ps

module cpu import cpu_pkg::*; (
	input logic clk,
	input logic reset,
	input logic run,
	input imem_load_t imem_load,
	output logic hlt,
	output word_t pc,
	output retire_t retire
);

	// fetch side
	instr_t instr;
	word_t next_pc;
	logic active;

	// decode and register file
	ctrl_t ctrl;
	reg_addr_t rd_addr1;
	reg_addr_t rd_addr2;
	word_t rd_data1;
	word_t rd_data2;

	// execute and writeback
	word_t alu_result;
	word_t mem_addr;
	logic branch_taken;
	word_t branch_target;
	logic reg_we;
	word_t reg_wdata;

	fetch_unit fetch_i (
		.clk(clk), .reset(reset), .run(run), .imem_load(imem_load),
		.branch_taken(branch_taken), .branch_target(branch_target),
		.pc(pc), .next_pc(next_pc), .instr(instr), .active(active), .hlt(hlt)
	);

	decode_unit decode_i (
		.instr(instr), .ctrl(ctrl), .rd_addr1(rd_addr1), .rd_addr2(rd_addr2)
	);

	// destination is always the rd field
	register_file regfile_i (
		.clk(clk), .reset(reset), .rd_addr1(rd_addr1), .rd_addr2(rd_addr2),
		.rd_data1(rd_data1), .rd_data2(rd_data2),
		.we(reg_we), .wr_addr(instr.rd), .wr_data(reg_wdata)
	);

	execute_unit execute_i (
		.clk(clk), .reset(reset), .active(active), .instr(instr), .ctrl(ctrl), .pc(pc),
		.rd_data1(rd_data1), .rd_data2(rd_data2), .alu_result(alu_result),
		.mem_addr(mem_addr), .branch_taken(branch_taken), .branch_target(branch_target)
	);

	// store data is read port 2, which decode points at rd for sw
	writeback_unit writeback_i (
		.clk(clk), .reset(reset), .active(active), .pc(pc), .instr(instr), .ctrl(ctrl),
		.alu_result(alu_result), .mem_addr(mem_addr), .store_data(rd_data2),
		.next_pc(next_pc), .reg_we(reg_we), .reg_wdata(reg_wdata), .retire(retire)
	);

endmodule

// File: test/cpu_sva.sv
`timescale 1ns/1ps

module cpu_sva import cpu_pkg::*; (
	input logic clk,
	input logic reset,
	input logic run,
	input logic hlt,
	input word_t pc,
	input retire_t retire
);

	// core comes out of reset idle at address zero
	reset_state: assert property (@(posedge clk)
		$fell(reset) |-> (pc == '0) && !hlt && !retire.valid)
		else $error("core not idle at pc zero after reset");

	// stall retires nothing and keeps the pc
	no_retire_without_run: assert property (@(posedge clk) disable iff (reset)
		!run |-> !retire.valid)
		else $error("retire.valid high while run is low");

	pc_held_without_run: assert property (@(posedge clk) disable iff (reset)
		!run |=> $stable(pc))
		else $error("pc moved while run was low");

	// hlt retires and raises hlt on the next edge
	hlt_follows_halt: assert property (@(posedge clk) disable iff (reset)
		retire.valid && retire.instr.opcode == OP_HLT |=> hlt)
		else $error("hlt did not rise after a halt retired");

	// once halted, everything freezes until reset
	hlt_sticky: assert property (@(posedge clk) disable iff (reset)
		hlt |=> hlt)
		else $error("hlt dropped without reset");

	halted_no_retire: assert property (@(posedge clk) disable iff (reset)
		hlt |-> !retire.valid)
		else $error("retire.valid high while halted");

	halted_pc_frozen: assert property (@(posedge clk) disable iff (reset)
		hlt |=> $stable(pc))
		else $error("pc moved while halted");

endmodule

bind cpu cpu_sva cpu_sva_i (
	.clk(clk), .reset(reset), .run(run), .hlt(hlt), .pc(pc), .retire(retire)
);

// File: test/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_tb import cpu_pkg::*; ();

	// load every imem word and run the program with some margin
	localparam int TIMEOUT_CYCLES = 256 + 200 + 5 + 100;
	localparam int PROG_LEN = 200;
	localparam int MEM_WORDS = 1 << `CPU_MEM_AW;

	logic clk;
	logic reset;
	logic run;
	imem_load_t imem_load;
	logic hlt;
	word_t pc;
	retire_t retire;

	// reference model state
	word_t prog [0:MEM_WORDS-1];
	word_t mreg [0:`CPU_NUM_REGS-1];
	word_t mdmem [0:MEM_WORDS-1];
	flags_t mflags;
	word_t mpc;
	logic mhalted;

	logic [31:0] lcg_state;
	int errors;
	int cycles;
	int dut_retired;
	int model_retired;
	int post_halt;
	int run_cycle;

	cpu cpu_i (
		.clk(clk), .reset(reset), .run(run), .imem_load(imem_load),
		.hlt(hlt), .pc(pc), .retire(retire)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// lcg step returning the upper bits with the longer period
	function logic [15:0] next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];
	endfunction

	// model register read with r0 hardwired to zero
	function word_t reg_value(input logic [3:0] r);
		return (r == 4'd0) ? 16'h0000 : mreg[r];
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Fail %s got %h expected %h at pc %h", name, got, exp, mpc);
		end
	endtask

	task automatic build_program();
		logic [3:0] op;
		logic [15:0] fields;
		// unused words and the last program word halt
		for (int i = 0; i < MEM_WORDS; i++) begin
			prog[i] = 16'hf000;
		end
		for (int i = 0; i < PROG_LEN - 1; i++) begin
			// opcodes 0 to e with hlt only at the end
			op = 4'(next_rand() % 16'd15);
			fields = next_rand();
			// loads and stores mostly use r0 as base so addresses repeat
			if ((op == 4'h8 || op == 4'h9) && fields[15:14] != 2'b00) begin
				fields[7:4] = 4'h0;
			end
			// forward offsets of 0 to 7 words only
			if (op == 4'hc) begin
				fields[8:3] = 6'h00;
			end
			prog[i] = {op, fields[11:0]};
		end
	endtask

	// compare this cycle with the model and then advance the model by one edge
	task automatic step_and_check();
		word_t ins;
		logic [3:0] op;
		logic [3:0] rd;
		logic [3:0] rs;
		logic [3:0] rt;
		logic [8:0] off;
		word_t a;
		word_t res;
		word_t addr;
		word_t wdata;
		word_t nxt;
		logic exp_valid;
		logic exp_reg_we;
		logic exp_mem_we;
		logic taken;
		int sum;
		flags_t f;

		exp_valid = run & ~mhalted;
		compare_value("hlt", hlt, mhalted);
		compare_value("pc", pc, mpc);
		compare_value("retire.valid", retire.valid, exp_valid);
		if (retire.valid === 1'b1) begin
			dut_retired++;
		end
		if (exp_valid) begin
			ins = prog[mpc[8:1]];
			op = ins[15:12];
			rd = ins[11:8];
			rs = ins[7:4];
			rt = ins[3:0];
			f = mflags;
			res = '0;
			addr = '0;
			wdata = '0;
			nxt = mpc + 16'd2;
			exp_reg_we = 1'b0;
			exp_mem_we = 1'b0;
			taken = 1'b0;
			case (op)
				4'h0, 4'h1: begin
					if (op == 4'h0) begin
						res = reg_value(rs) + reg_value(rt);
						sum = int'($signed(reg_value(rs))) + int'($signed(reg_value(rt)));
					end else begin
						res = reg_value(rs) - reg_value(rt);
						sum = int'($signed(reg_value(rs))) - int'($signed(reg_value(rt)));
					end
					// overflow when the true sum leaves the 16-bit signed range
					f.v = (sum > 32767) || (sum < -32768);
					f.n = res[15];
					exp_reg_we = 1'b1;
				end
				4'h2: begin
					res = reg_value(rs) ^ reg_value(rt);
					exp_reg_we = 1'b1;
				end
				4'h3: begin
					res = reg_value(rs) << rt;
					exp_reg_we = 1'b1;
				end
				4'h4: begin
					a = reg_value(rs);
					res = a >> rt;
					// vacated upper bits take the sign
					if (a[15]) begin
						res = res | ~(16'hffff >> rt);
					end
					exp_reg_we = 1'b1;
				end
				4'h8, 4'h9: begin
					addr = reg_value(rs) + ({{12{rt[3]}}, rt} << 1);
					if (op == 4'h8) begin
						res = mdmem[addr[8:1]];
						exp_reg_we = 1'b1;
					end else begin
						wdata = reg_value(rd);
						exp_mem_we = 1'b1;
					end
				end
				4'ha, 4'hb: begin
					a = reg_value(rd);
					res = (op == 4'ha) ? {a[15:8], ins[7:0]} : {ins[7:0], a[7:0]};
					exp_reg_we = 1'b1;
				end
				4'hc: begin
					case (ins[11:9])
						3'b000: taken = ~mflags.z;
						3'b001: taken = mflags.z;
						3'b010: taken = ~mflags.z & ~mflags.n;
						3'b011: taken = mflags.n;
						3'b100: taken = ~mflags.n;
						3'b101: taken = mflags.z | mflags.n;
						3'b110: taken = mflags.v;
						default: taken = 1'b1;
					endcase
					off = ins[8:0];
					if (taken) begin
						nxt = mpc + 16'd2 + ({{7{off[8]}}, off} << 1);
					end
				end
				4'he: begin
					res = mpc + 16'd2;
					exp_reg_we = 1'b1;
				end
				// hlt stays on its own address
				4'hf: nxt = mpc;
				default: ;
			endcase
			// z follows every alu opcode
			if (op <= 4'h4) begin
				f.z = (res == 16'h0000);
			end
			compare_value("retire.pc", retire.pc, mpc);
			compare_value("retire.instr", retire.instr, ins);
			compare_value("retire.reg_we", retire.reg_we, exp_reg_we);
			compare_value("retire.rd", retire.rd, rd);
			compare_value("retire.mem_we", retire.mem_we, exp_mem_we);
			compare_value("retire.next_pc", retire.next_pc, nxt);
			if (exp_reg_we) begin
				compare_value("retire.reg_wdata", retire.reg_wdata, res);
			end
			if (exp_mem_we) begin
				compare_value("retire.mem_addr", retire.mem_addr, addr);
				compare_value("retire.mem_wdata", retire.mem_wdata, wdata);
			end
			if (exp_reg_we && rd != 4'd0) begin
				mreg[rd] = res;
			end
			if (exp_mem_we) begin
				mdmem[addr[8:1]] = wdata;
			end
			mflags = f;
			mpc = nxt;
			if (op == 4'hf) begin
				mhalted = 1'b1;
			end
			model_retired++;
		end
	endtask

	// hard stop in case the core never halts
	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, the core did not finish the program", cycles);
		$display("Some tests failed");
		$finish;
	end

	initial begin
		reset = 1'b1;
		run = 1'b0;
		imem_load = '0;
		errors = 0;
		dut_retired = 0;
		model_retired = 0;
		post_halt = 0;
		run_cycle = 0;
		lcg_state = 32'd90992;
		build_program();
		for (int i = 0; i < `CPU_NUM_REGS; i++) begin
			mreg[i] = '0;
		end
		for (int i = 0; i < MEM_WORDS; i++) begin
			mdmem[i] = '0;
		end
		mflags = '0;
		mpc = '0;
		mhalted = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		// fill imem with run low while nothing may retire
		for (int i = 0; i < MEM_WORDS; i++) begin
			@(negedge clk);
			step_and_check();
			@(posedge clk);
			#1;
			imem_load.en = 1'b1;
			imem_load.addr = i[7:0];
			imem_load.data = prog[i];
		end
		@(posedge clk);
		#1;
		imem_load = '0;
		run = 1'b1;
		// keep going a few cycles past hlt to see the core stay frozen
		while (!(mhalted && post_halt >= 8)) begin
			@(negedge clk);
			step_and_check();
			if (mhalted) begin
				post_halt++;
			end
			@(posedge clk);
			#1;
			run_cycle++;
			// short stall partway through the program
			run = !(run_cycle >= 40 && run_cycle < 43);
		end
		compare_value("retired_count", dut_retired, model_retired);
		$display("errors %0d, retired %0d, model retired %0d", errors, dut_retired,
			model_retired);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: files.f
+incdir+design
design/cpu_pkg.sv
design/fetch_unit.sv
design/decode_unit.sv
design/register_file.sv
design/execute_unit.sv
design/writeback_unit.sv
design/cpu.sv
test/cpu_sva.sv
test/cpu_tb.sv

// File: run.sh
#!/bin/sh
# build and run the cpu testbench with verilator, result comes from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module cpu_tb -f files.f -o cpu_sim \
	&& ./obj_dir/cpu_sim > sim.log 2>&1 \
	|| echo "Some tests failed" >> sim.log
cat sim.log
grep -q "Some tests failed" sim.log && exit 1 || exit 0
